// File: src/uart_pkg.sv
`default_nettype none

//----------------------------------------------------------------------------
// Serial line constants shared by the receiver and the transmitter
//----------------------------------------------------------------------------
package uart_pkg;

  // Board clock, 12 MHz oscillator
  localparam int CLK_HZ = 12_000_000;

  // Line rate
  localparam int BAUD = 115_200;

  // Clocks per bit, truncated (about 0.2% fast, well inside the UART margin)
  localparam int BIT_TICKS = CLK_HZ / BAUD;

  // From the start edge to the middle of the start bit
  localparam int HALF_TICKS = BIT_TICKS / 2;

  // Bit-time counters must reach BIT_TICKS - 1
  localparam int TICK_W = $clog2(BIT_TICKS);

  // 8N1 framing only
  localparam int DATA_BITS = 8;

endpackage : uart_pkg

`default_nettype wire

// File: src/echo_pkg.sv
`default_nettype none

//----------------------------------------------------------------------------
// Data-path types and buffer sizing for the echo blocks
//----------------------------------------------------------------------------
package echo_pkg;

  // One character on the line
  typedef logic [7:0] byte_t;

  // What the receiver hands over on each rs strobe
  typedef struct packed {
    byte_t data;       // Received character
    logic  frame_err;  // Stop bit was sampled low
  } rx_beat_t;

  // Echo buffer entries
  localparam int FIFO_DEPTH = 4;

  // Pointer width, pointers wrap naturally at FIFO_DEPTH
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);

endpackage : echo_pkg

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

//----------------------------------------------------------------------------
// UART receiver, 8N1
//----------------------------------------------------------------------------
module uart_rx import uart_pkg::*, echo_pkg::*; (
  input  logic     clk,    // System clock
  input  logic     rst_n,  // Async reset, active low
  input  logic     rx,     // Serial line, idles high
  output rx_beat_t beat,   // Byte plus framing flag, valid with rs
  output logic     rs      // One-cycle strobe at mid stop bit
);

  typedef enum logic [1:0] {
    IDLE,   // Waiting for a falling edge
    START,  // Counting to the middle of the start bit
    DATA,   // Shifting in the data bits
    STOP    // Waiting for the middle of the stop bit
  } state_t;

  state_t            state;
  logic              rx_s1;     // First synchronizer stage
  logic              rx_s2;     // Second stage, previous value of rx_s1
  logic [TICK_W-1:0] tick;      // Clocks into the current bit
  logic [2:0]        bit_idx;   // Data bit being received
  byte_t             shreg;     // Data bits, LSB arrives first
  logic              fall;
  logic              half_end;
  logic              bit_end;

  assign fall     = rx_s2 & ~rx_s1;                        // Start edge seen
  assign half_end = (tick == TICK_W'(HALF_TICKS - 1));
  assign bit_end  = (tick == TICK_W'(BIT_TICKS - 1));

  //--------------------------------------------------------------------------
  // Control FSM
  //--------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      state   <= IDLE;
      tick    <= '0;
      bit_idx <= '0;
      rs      <= 1'b0;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rs    <= 1'b0;                                       // Strobe by default off
      tick  <= tick + 1'b1;

      case (state)
        IDLE: begin
          // Edge is seen two clocks late, so the count starts at 2 to keep
          // every sample point at the true middle of its bit
          tick <= TICK_W'(2);
          if (fall) state <= START;
        end

        START: begin
          if (half_end) begin
            tick    <= '0;
            bit_idx <= '0;
            state   <= rx_s1 ? IDLE : DATA;                // Glitch, back to idle
          end
        end

        DATA: begin
          if (bit_end) begin
            tick    <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'(DATA_BITS - 1)) state <= STOP;
          end
        end

        STOP: begin
          if (bit_end) begin
            state <= IDLE;
            rs    <= 1'b1;                                 // Beat is updated alongside
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // Data path
  //--------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == DATA && bit_end)
      shreg <= {rx_s1, shreg[7:1]};                        // Shift right, LSB first
    if (state == STOP && bit_end) begin
      beat.data      <= shreg;
      beat.frame_err <= ~rx_s1;                            // Stop bit must be high
    end
  end

  // Frames are at least ten bits long, so strobes never touch
  a_rs_single : assert property (@(posedge clk) disable iff (!rst_n) rs |=> !rs)
    else $error("uart_rx: rs high in two consecutive cycles");

endmodule : uart_rx

`default_nettype wire

// File: src/byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none

//----------------------------------------------------------------------------
// Echo buffer between receiver and transmitter
//----------------------------------------------------------------------------
module byte_fifo import echo_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  rx_beat_t beat,      // From the receiver
  input  logic     rs,        // Beat valid
  input  logic     busy,      // Transmitter is sending
  output byte_t    data,      // Byte for the transmitter
  output logic     ws,        // Write strobe to the transmitter
  output byte_t    last,      // Last good byte received
  output logic     overflow   // Sticky, good byte lost to a full buffer
);

  byte_t              mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;     // One bit wider, holds FIFO_DEPTH
  logic               good;
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  assign good  = rs & ~beat.frame_err;                     // Bad frames never enter
  assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign push  = good & ~full;
  // ws blocks a second pop while busy has not risen yet
  assign pop   = ~empty & ~busy & ~ws;

  // Pointers, count and flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      ws       <= 1'b0;
      last     <= '0;
      overflow <= 1'b0;
    end else begin
      ws <= pop;
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (good) last <= beat.data;
      if (good && full) overflow <= 1'b1;                  // Stays set until reset

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                           // Both or neither
      endcase
    end
  end

  // Storage and read register
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= beat.data;
    if (pop)  data <= mem[rd_ptr];                         // Valid with ws
  end

  a_count_max : assert property (@(posedge clk) disable iff (!rst_n)
    count <= (FIFO_AW + 1)'(FIFO_DEPTH))
    else $error("byte_fifo: count above FIFO_DEPTH");

  // Transmitter handshake, busy comes back one clock after ws
  a_ws_idle : assert property (@(posedge clk) disable iff (!rst_n) $rose(ws) |-> !busy)
    else $error("byte_fifo: ws raised while transmitter busy");

endmodule : byte_fifo

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

//----------------------------------------------------------------------------
// UART transmitter, 8N1
//----------------------------------------------------------------------------
module uart_tx import uart_pkg::*, echo_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  byte_t data,   // Character to send, sampled on ws
  input  logic  ws,     // Write strobe, one cycle
  output logic  tx,     // Serial line
  output logic  busy    // High for the whole frame
);

  logic [DATA_BITS+1:0] shreg;     // Stop, data, start; bit 0 is on the line
  logic [TICK_W-1:0]    tick;      // Clocks into the current bit
  logic [3:0]           bit_idx;   // Bit of the frame being sent
  logic                 bit_end;

  assign bit_end = (tick == TICK_W'(BIT_TICKS - 1));

  // Line comes straight from a flop, no glitches on tx
  assign tx = shreg[0];

  //--------------------------------------------------------------------------
  // Frame sequencer
  //--------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg   <= '1;                                       // Line idles high
      tick    <= '0;
      bit_idx <= '0;
      busy    <= 1'b0;
    end else if (ws) begin
      shreg   <= {1'b1, data, 1'b0};                       // Start bit goes out now
      tick    <= '0;
      bit_idx <= '0;
      busy    <= 1'b1;
    end else if (busy) begin
      tick <= tick + 1'b1;
      if (bit_end) begin
        tick    <= '0;
        shreg   <= {1'b1, shreg[DATA_BITS+1:1]};           // Ones fill behind
        bit_idx <= bit_idx + 1'b1;
        // Last bit was the stop bit
        if (bit_idx == 4'(DATA_BITS + 1)) busy <= 1'b0;
      end
    end
  end

  // No ws check here, the FIFO waits for busy to drop
  a_ws_not_busy : assert property (@(posedge clk) disable iff (!rst_n) ws |-> !busy)
    else $error("uart_tx: ws while busy");

endmodule : uart_tx

`default_nettype wire

// File: src/echo.sv
`timescale 1ns/100ps
`default_nettype none

//----------------------------------------------------------------------------
// Serial echo: receiver, buffer, transmitter
//----------------------------------------------------------------------------
module echo import echo_pkg::*; (
  input  logic       clk,       // 12 MHz board clock
  input  logic       rst_n,     // External reset, active low
  input  logic       rx,        // Serial in, from the host
  output logic       tx,        // Serial out, back to the host
  output logic [3:0] leds,      // Low nibble of the last good byte
  output logic       act,       // Line activity, for a LED
  output logic       overflow   // A good byte was dropped
);

  rx_beat_t beat;   // Receiver to buffer
  logic     rs;
  byte_t    data;   // Buffer to transmitter
  logic     ws;
  logic     busy;
  byte_t    last;

  uart_rx rx0 (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .beat  (beat),
    .rs    (rs)
  );

  byte_fifo fifo0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .beat     (beat),
    .rs       (rs),
    .busy     (busy),
    .data     (data),
    .ws       (ws),
    .last     (last),
    .overflow (overflow)
  );

  uart_tx tx0 (
    .clk   (clk),
    .rst_n (rst_n),
    .data  (data),
    .ws    (ws),
    .tx    (tx),
    .busy  (busy)
  );

  assign leds = last[3:0];
  assign act  = rx;   // Raw level, blinks with traffic

endmodule : echo

`default_nettype wire

// File: dv/echo_tb.sv
`timescale 1ns/100ps
`default_nettype none

module echo_tb import uart_pkg::*, echo_pkg::*; ();

  logic        clk;
  logic        rst_n;
  logic        rx;
  logic        tx;
  logic [3:0]  leds;
  logic        act;
  logic        overflow;

  byte_t       ref_q[$];     // Good bytes sent, oldest first
  byte_t       last_good;    // Most recent good byte fully sent on rx
  byte_t       echo_byte;    // Byte rebuilt from tx
  byte_t       exp_byte;     // Reference entry it is held against
  logic        exp_found;
  logic        echo_stop;    // Stop bit level seen on tx
  logic        chk_echo;     // One-cycle pulse per echoed byte
  logic        leds_chk;     // Pulse after a bad frame
  logic        end_chk;      // Pulse after the overflow burst
  int          phase;
  int          echo_cnt;
  int          echo_mark;    // Echo count before the bad frame
  logic [31:0] rng;

  echo dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .tx       (tx),
    .leds     (leds),
    .act      (act),
    .overflow (overflow)
  );

  always #10 clk = ~clk;  // 20 ns period

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // Called on a falling edge, holds the level for n clocks
  task automatic drive_level(input logic v, input int n);
    rx = v;
    repeat (n) @(negedge clk);
  endtask

  //--------------------------------------------------------------------------
  // Serial line model, 8N1 with optional bad or short stop bit
  //--------------------------------------------------------------------------
  task automatic send_char(input byte_t b, input logic bad_stop, input logic short_stop);
    int i;
    if (!bad_stop) ref_q.push_back(b);                   // Expected on tx later
    drive_level(1'b0, BIT_TICKS);                        // Start bit
    for (i = 0; i < DATA_BITS; i++)
      drive_level(b[i], BIT_TICKS);                      // LSB first
    drive_level(~bad_stop, short_stop ? HALF_TICKS : BIT_TICKS);
    if (bad_stop) drive_level(1'b1, BIT_TICKS);          // Line back to idle
    else last_good = b;
  endtask

  task automatic wait_echoes(input int target);
    int n;
    n = 0;
    while (echo_cnt < target) begin
      if (n > 40 * 10 * BIT_TICKS) abort_run("timeout waiting for echoed bytes on tx");
      else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  // Idle means three frame times of tx high in a row
  task automatic wait_tx_quiet();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 3 * 10 * BIT_TICKS) begin
      if (n > 60 * 10 * BIT_TICKS) abort_run("timeout waiting for tx to go idle");
      else begin
        @(negedge clk);
        quiet = tx ? quiet + 1 : 0;
        n++;
      end
    end
  endtask

  //--------------------------------------------------------------------------
  // tx monitor, samples every bit at its middle
  //--------------------------------------------------------------------------
  initial begin : tx_monitor
    byte_t b;
    int    n;
    int    i;
    chk_echo  = 1'b0;
    echo_cnt  = 0;
    exp_found = 1'b0;
    exp_byte  = '0;
    echo_byte = '0;
    echo_stop = 1'b1;
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n > 100) abort_run("reset was never released");
      else begin
        @(negedge clk);
        n++;
      end
    end
    forever begin
      n = 0;
      while (tx !== 1'b0) begin                          // Hunt for a start bit
        if (n > 20 * 10 * BIT_TICKS) abort_run("no start bit on tx for too long");
        else begin
          @(negedge clk);
          n++;
        end
      end
      repeat (HALF_TICKS) @(negedge clk);                // Middle of start bit
      for (i = 0; i < DATA_BITS; i++) begin
        repeat (BIT_TICKS) @(negedge clk);
        b[i] = tx;
      end
      repeat (BIT_TICKS) @(negedge clk);
      echo_stop = tx;                                    // Middle of stop bit
      exp_found = 1'b0;
      if (phase != 5) begin                              // Strict order, no losses
        if (ref_q.size() > 0) begin
          exp_byte  = ref_q.pop_front();
          exp_found = 1'b1;
        end
      end else begin
        // Dropped bytes are skipped, each entry used at most once
        while (!exp_found && ref_q.size() > 0) begin
          exp_byte  = ref_q.pop_front();
          exp_found = (exp_byte == b);
        end
      end
      echo_byte = b;
      echo_cnt++;
      chk_echo = 1'b1;
      @(negedge clk);
      chk_echo = 1'b0;
    end
  end

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------
  a_idle_tx : assert property (@(posedge clk) disable iff (!rst_n) (phase == 1) |-> tx)
    else abort_run($sformatf("ERR tx expected 1 actual %h", tx));
  a_idle_leds : assert property (@(posedge clk) disable iff (!rst_n)
    (phase == 1) |-> (leds == 4'h0))
    else abort_run($sformatf("ERR leds expected 0 actual %h", leds));
  a_no_ovf : assert property (@(posedge clk) disable iff (!rst_n)
    (phase >= 1 && phase <= 4) |-> !overflow)
    else abort_run($sformatf("ERR overflow expected 0 actual %h", overflow));
  a_ovf_sticky : assert property (@(posedge clk) disable iff (!rst_n) overflow |=> overflow)
    else abort_run("overflow flag cleared itself after being set");
  a_ovf_end : assert property (@(posedge clk) disable iff (!rst_n) end_chk |-> overflow)
    else abort_run($sformatf("ERR overflow expected 1 actual %h", overflow));
  a_act : assert property (@(posedge clk) act == rx)  // Straight wire
    else abort_run($sformatf("ERR act expected %h actual %h", rx, act));
  a_echo_stop : assert property (@(posedge clk) disable iff (!rst_n) chk_echo |-> echo_stop)
    else abort_run($sformatf("ERR tx expected 1 actual %h", echo_stop));
  a_echo_found : assert property (@(posedge clk) disable iff (!rst_n) chk_echo |-> exp_found)
    else abort_run($sformatf("echoed byte %h has no matching byte left to match", echo_byte));
  a_echo_val : assert property (@(posedge clk) disable iff (!rst_n)
    chk_echo |-> (echo_byte == exp_byte))
    else abort_run($sformatf("ERR echo_byte expected %h actual %h", exp_byte, echo_byte));
  a_leds_stream : assert property (@(posedge clk) disable iff (!rst_n)
    (chk_echo && phase == 3) |-> (leds == last_good[3:0]))
    else abort_run($sformatf("ERR leds expected %h actual %h", last_good[3:0], leds));
  a_leds_hold : assert property (@(posedge clk) disable iff (!rst_n)
    leds_chk |-> (leds == last_good[3:0]))
    else abort_run($sformatf("ERR leds expected %h actual %h", last_good[3:0], leds));
  a_no_echo : assert property (@(posedge clk) disable iff (!rst_n)
    leds_chk |-> (echo_cnt == echo_mark))
    else abort_run($sformatf("ERR echo_cnt expected %h actual %h", echo_mark, echo_cnt));

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------
  initial begin : stimulus
    int i;
    clk       = 1'b0;
    rst_n     = 1'b0;
    rx        = 1'b1;                                    // Line idles high
    leds_chk  = 1'b0;
    end_chk   = 1'b0;
    phase     = 0;
    echo_mark = 0;
    last_good = '0;
    rng       = 32'h1c5f_8f52;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    phase = 1;                                           // Idle line after reset
    repeat (4 * 10 * BIT_TICKS) @(negedge clk);
    phase = 2;                                           // One byte round trip
    rng = next_rand(rng);
    send_char(rng[7:0], 1'b0, 1'b0);
    wait_echoes(1);
    phase = 3;
    for (i = 0; i < 20; i++) begin                       // Back to back, full stop bits
      rng = next_rand(rng);
      send_char(rng[7:0], 1'b0, 1'b0);
    end
    wait_echoes(21);
    phase = 4;                                           // Bad stop bit is dropped
    echo_mark = echo_cnt;
    rng = next_rand(rng);
    send_char(rng[7:0], 1'b1, 1'b0);
    repeat (2 * 10 * BIT_TICKS) @(negedge clk);
    leds_chk = 1'b1;
    @(negedge clk);
    leds_chk = 1'b0;
    rng = next_rand(rng);
    send_char(rng[7:0], 1'b0, 1'b0);
    wait_echoes(22);
    phase = 5;
    // Short stop bits outrun the transmitter until the FIFO fills
    for (i = 0; i < 100; i++) begin
      rng = next_rand(rng);
      send_char(rng[7:0], 1'b0, 1'b1);
    end
    wait_tx_quiet();
    end_chk = 1'b1;
    @(negedge clk);
    end_chk = 1'b0;
    $display("TB PASSED");
    $finish;
  end

endmodule : echo_tb

`default_nettype wire

// File: verilog.f
src/uart_pkg.sv
src/echo_pkg.sv
src/uart_rx.sv
src/byte_fifo.sv
src/uart_tx.sv
src/echo.sv
dv/echo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the echo testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module echo_tb \
    -f verilog.f -o echo_sim \
  && ./obj_dir/echo_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "TB PASSED" sim.log && exit 0 || { echo "Pass line not found in sim.log"; exit 1; }
